// File: Makefile
# Verilator build and run for the write-back path testbench.

VERILATOR ?= verilator
TOP       ?= wb_path_tb
RTL_TOP   ?= wb_path_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/wb_path_chk.sv
// CDB arbiter checker
`default_nettype none

module wb_path_chk (
   input logic                             clk,
   input logic                             rst_n,
   input logic [core_cfg_pkg::fu_ways-1:0] fu_valid,
   input logic [core_cfg_pkg::fu_ways-1:0] fu_ready,
   input logic                             cdb_valid
);

   // number of assertion failures seen, watched by the testbench.
   int viol_cnt = 0;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grant properties
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // at most one unit owns the bus in any cycle.
   grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(fu_ready))
   else
   begin
      $error("cdb grant is not one-hot: fu_ready=%b", fu_ready);
      viol_cnt = viol_cnt + 1;
   end

   // the bus carries a result exactly when some unit is granted.
   bus_valid_match: assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid == (|fu_ready))
   else
   begin
      $error("cdb_valid=%b disagrees with fu_ready=%b", cdb_valid, fu_ready);
      viol_cnt = viol_cnt + 1;
   end

   // a grant only goes to a unit that holds a result.
   grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      (fu_ready & ~fu_valid) == '0)
   else
   begin
      $error("grant without request: fu_ready=%b fu_valid=%b", fu_ready, fu_valid);
      viol_cnt = viol_cnt + 1;
   end

endmodule

bind cdb_arbiter wb_path_chk u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .fu_valid  (fu_valid),
   .fu_ready  (fu_ready),
   .cdb_valid (cdb_valid)
);

`default_nettype wire

// File: dv/wb_path_tb.sv
// Write-back path testbench
`default_nettype none

module wb_path_tb;

   localparam int clk_period = 20;
   localparam int drive_dly  = 2;
   localparam int n_random   = 200;
   // upper bound on the directed operations issued before the random mix.
   localparam int n_directed = 40;
   // every operation is given two multiplier latencies, which covers the
   // retire stalls of the random phase with a wide margin.
   localparam int op_budget    = 2 * (core_cfg_pkg::mul_steps + 4);
   localparam int limit_cycles = 16 + (n_directed + n_random) * op_budget;

   logic                  clk;
   logic                  rst_n;
   logic                  issue_valid;
   wb_types_pkg::issue_t  issue_in;
   logic                  issue_ready;
   logic                  retire_valid;
   wb_types_pkg::retire_t retire_out;
   logic                  retire_ready;

   // expected retirements in issue order.
   wb_types_pkg::retire_t expect_q [$];
   integer                seed = 61;
   integer                ready_seed = 61 + 7;
   // 0 keeps retire_ready high, 1 holds it low, 2 toggles it at random.
   int                    ready_mode = 0;

   wb_path_top dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid),
      .issue        (issue_in),
      .issue_ready  (issue_ready),
      .retire_valid (retire_valid),
      .retire       (retire_out),
      .retire_ready (retire_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model and error reporting
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // the product is formed at double width and then cut to data_w bits.
   function automatic logic [core_cfg_pkg::data_w-1:0] ref_result(
      input wb_types_pkg::op_e               op,
      input logic [core_cfg_pkg::data_w-1:0] a,
      input logic [core_cfg_pkg::data_w-1:0] b
   );
      logic [2*core_cfg_pkg::data_w-1:0] full;
      full = a * b;
      case (op)
         wb_types_pkg::op_add: return a + b;
         wb_types_pkg::op_sub: return a - b;
         wb_types_pkg::op_and: return a & b;
         wb_types_pkg::op_xor: return a ^ b;
         wb_types_pkg::op_mul: return full[core_cfg_pkg::data_w-1:0];
         default:              return '0;
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // holds the operation on the port until a rising edge accepts it.
   // issue_ready is sampled at the falling edge, where it is settled.
   task automatic send_op(
      input wb_types_pkg::op_e               op,
      input logic [core_cfg_pkg::data_w-1:0] a,
      input logic [core_cfg_pkg::data_w-1:0] b,
      input logic [core_cfg_pkg::tag_w-1:0]  tag
   );
      wb_types_pkg::retire_t want;
      logic                  taken;
      want.data    = ref_result(op, a, b);
      want.tag     = tag;
      issue_in.op  = op;
      issue_in.a   = a;
      issue_in.b   = b;
      issue_in.tag = tag;
      issue_valid  = 1'b1;
      taken        = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken = issue_ready;
         if (taken)
            expect_q.push_back(want);
         @(posedge clk);
         #drive_dly;
      end
      issue_valid = 1'b0;
   endtask

   // waits for every outstanding operation to retire.
   // the bound grows with the number of operations still in flight.
   task automatic wait_drain();
      int waited;
      int bound;
      waited = 0;
      bound  = (expect_q.size() + 1) * op_budget;
      while (expect_q.size() != 0 && waited < bound)
      begin
         @(posedge clk);
         waited = waited + 1;
      end
      assert (expect_q.size() == 0)
      else report_mismatch($sformatf("%0d operations never retired", expect_q.size()));
      repeat (4) @(posedge clk);
      #drive_dly;
   endtask

   // random opcodes and operands with idle gaps of zero to two cycles.
   task automatic run_random(input int n);
      int          k;
      int          gap;
      logic [31:0] ra;
      logic [31:0] rb;
      logic [31:0] rt;
      for (int i = 0; i < n; i++)
      begin
         gap = $unsigned($random(seed)) % 3;
         repeat (gap)
         begin
            @(posedge clk);
            #drive_dly;
         end
         k  = $unsigned($random(seed)) % 5;
         ra = $random(seed);
         rb = $random(seed);
         rt = $random(seed);
         send_op(wb_types_pkg::op_e'(k), ra, rb, rt[core_cfg_pkg::tag_w-1:0]);
      end
   endtask

   // issues ALU adds with retire held low and counts accepted issues
   // until issue_ready falls.
   task automatic fill_until_full();
      int                    accepted;
      logic                  stalled;
      wb_types_pkg::retire_t want;
      accepted    = 0;
      stalled     = 1'b0;
      issue_valid = 1'b1;
      while (!stalled && accepted <= core_cfg_pkg::rob_depth)
      begin
         issue_in.op  = wb_types_pkg::op_add;
         issue_in.a   = 32'(accepted);
         issue_in.b   = 32'h0000_0100;
         issue_in.tag = 5'(accepted + 20);
         want.data    = ref_result(wb_types_pkg::op_add, issue_in.a, issue_in.b);
         want.tag     = issue_in.tag;
         @(negedge clk);
         if (issue_ready)
         begin
            expect_q.push_back(want);
            accepted = accepted + 1;
            @(posedge clk);
            #drive_dly;
         end
         else
            stalled = 1'b1;
      end
      @(posedge clk);
      #drive_dly;
      issue_valid = 1'b0;
      assert (stalled && accepted == core_cfg_pkg::rob_depth)
      else report_mismatch($sformatf("issue_ready fell after %0d issues", accepted));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // retire side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // the mode is taken at the rising edge, before the sequence can move it.
   initial
   begin
      int mode;
      retire_ready = 1'b0;
      forever
      begin
         @(posedge clk);
         mode = ready_mode;
         #drive_dly;
         case (mode)
            0:       retire_ready = 1'b1;
            1:       retire_ready = 1'b0;
            default: retire_ready = ($random(ready_seed) % 4) != 0;
         endcase
      end
   end

   // every retire handshake must match the oldest outstanding operation.
   initial
   begin
      wb_types_pkg::retire_t want;
      forever
      begin
         @(negedge clk);
         if (rst_n && retire_valid && retire_ready)
         begin
            assert (expect_q.size() != 0)
            else report_mismatch("retire with no operation outstanding");
            want = expect_q.pop_front();
            assert (retire_out.data == want.data)
            else report_mismatch($sformatf("retire data %h, expected %h",
                                           retire_out.data, want.data));
            assert (retire_out.tag == want.tag)
            else report_mismatch($sformatf("retire tag %0d, expected %0d",
                                           retire_out.tag, want.tag));
         end
      end
   end

   // a failed arbiter assertion ends the run at once.
   initial
   begin
      wait (dut.u_arb.u_chk.viol_cnt != 0);
      abort_run("arbiter checker flagged a bus protocol error");
   end

   initial
   begin
      #(limit_cycles * clk_period);
      abort_run($sformatf("timeout: tests did not finish within %0d cycles", limit_cycles));
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial
   begin
      rst_n       = 1'b0;
      issue_valid = 1'b0;
      issue_in    = '0;
      repeat (16) @(posedge clk);
      #drive_dly;
      rst_n = 1'b1;
      // the buffer takes no issue in the first cycle out of reset.
      @(negedge clk);
      assert (!issue_ready && !retire_valid)
      else report_mismatch("issue_ready or retire_valid high right after reset");
      @(posedge clk);
      #drive_dly;

      // directed ALU operations with edge operands.
      send_op(wb_types_pkg::op_add, 32'hffff_ffff, 32'h0000_0001, 5'd1);
      send_op(wb_types_pkg::op_add, 32'h7fff_ffff, 32'h0000_0001, 5'd2);
      send_op(wb_types_pkg::op_sub, 32'h0000_0000, 32'h0000_0001, 5'd3);
      send_op(wb_types_pkg::op_and, 32'haaaa_aaaa, 32'h5555_ffff, 5'd4);
      send_op(wb_types_pkg::op_xor, 32'hffff_ffff, 32'h1234_5678, 5'd5);
      wait_drain();

      // directed multiplies, including products that overflow data_w.
      send_op(wb_types_pkg::op_mul, 32'h0000_0000, 32'h0001_2345, 5'd6);
      send_op(wb_types_pkg::op_mul, 32'hffff_ffff, 32'hffff_ffff, 5'd7);
      send_op(wb_types_pkg::op_mul, 32'h0001_0000, 32'h0001_0000, 5'd8);
      send_op(wb_types_pkg::op_mul, 32'h1234_5678, 32'h9abc_def0, 5'd9);
      send_op(wb_types_pkg::op_mul, 32'hffff_ffff, 32'h0000_0002, 5'd10);
      wait_drain();

      // the ALU results reach the bus first but must retire behind the multiply.
      send_op(wb_types_pkg::op_mul, 32'h0000_1234, 32'h0000_5678, 5'd11);
      send_op(wb_types_pkg::op_add, 32'h0000_0010, 32'h0000_0020, 5'd12);
      send_op(wb_types_pkg::op_sub, 32'h0000_0100, 32'h0000_0001, 5'd13);
      send_op(wb_types_pkg::op_xor, 32'h0f0f_0f0f, 32'hffff_0000, 5'd14);
      send_op(wb_types_pkg::op_and, 32'hdead_beef, 32'h0000_ffff, 5'd15);
      wait_drain();

      // back-pressure fills the buffer; release drains it in order.
      ready_mode = 1;
      @(posedge clk);
      #drive_dly;
      fill_until_full();
      ready_mode = 0;
      wait_drain();

      ready_mode = 2;
      run_random(n_random);
      ready_mode = 0;
      wait_drain();
      // any retire beyond the issued stream is caught by the compare process.
      repeat (20) @(posedge clk);

      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/alu_unit.sv
// Single-cycle ALU
`default_nettype none

module alu_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  dispatch,
   input  wb_types_pkg::fu_op_t  fu_op,
   output logic                  busy,
   output logic                  fu_valid,
   input  logic                  fu_ready,
   output wb_types_pkg::cdb_t    fu_result
);

   logic                            take;
   logic [core_cfg_pkg::data_w-1:0] alu_res;
   wb_types_pkg::cdb_t              res_q;

   // the ALU owns every opcode except the multiply.
   assign take = dispatch && (fu_op.iss.op != wb_types_pkg::op_mul);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // operation
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      case (fu_op.iss.op)
         wb_types_pkg::op_add: alu_res = fu_op.iss.a + fu_op.iss.b;
         wb_types_pkg::op_sub: alu_res = fu_op.iss.a - fu_op.iss.b;
         wb_types_pkg::op_and: alu_res = fu_op.iss.a & fu_op.iss.b;
         wb_types_pkg::op_xor: alu_res = fu_op.iss.a ^ fu_op.iss.b;
         // the multiply is never taken here.
         default:              alu_res = '0;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // result hold register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // the payload loads only on a new operation.
   // between loads it holds, so an ungranted result stays on the bus.
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         res_q.data   <= alu_res;
         res_q.tag    <= fu_op.iss.tag;
         res_q.rob_id <= fu_op.rob_id;
      end
   end

   // a new operation wins over the grant of the old one.
   // that lets a granted result be replaced on the same edge.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         fu_valid <= 1'b0;
      end
      else if (take)
      begin
         fu_valid <= 1'b1;
      end
      else if (fu_ready)
      begin
         fu_valid <= 1'b0;
      end
   end

   assign fu_result = res_q;

   // busy while a result waits for the bus.
   // the buffer then holds back ALU issues so the result is not overwritten.
   assign busy = fu_valid && !fu_ready;

endmodule

`default_nettype wire

// File: hw/cdb_arbiter.sv
// Common data bus arbiter
`default_nettype none

module cdb_arbiter (
   input  logic                                            clk,
   input  logic                                            rst_n,
   input  logic [core_cfg_pkg::fu_ways-1:0]                fu_valid,
   input  wb_types_pkg::cdb_t [core_cfg_pkg::fu_ways-1:0]  fu_result,
   output logic [core_cfg_pkg::fu_ways-1:0]                fu_ready,
   output logic                                            cdb_valid,
   output wb_types_pkg::cdb_t                              cdb
);

   // clk and rst_n carry no logic here.
   // they give the bound checker a clock and a reset to sample on.

   logic [core_cfg_pkg::fu_ways-1:0]    grant;
   logic [$bits(wb_types_pkg::cdb_t)-1:0] mux;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fixed priority grant
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // the lowest requesting way gets the bus.
   // the reorder buffer never refuses a write, so the grant is the ready.
   always_comb
   begin
      logic found;
      found = 1'b0;
      grant = '0;
      for (int i = 0; i < core_cfg_pkg::fu_ways; i++)
      begin
         if (fu_valid[i] && !found)
         begin
            grant[i] = 1'b1;
            found = 1'b1;
         end
      end
   end

   assign fu_ready = grant;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // result multiplexer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // at most one grant bit is set, so an and-or tree selects the winner.
   always_comb
   begin
      mux = '0;
      for (int i = 0; i < core_cfg_pkg::fu_ways; i++)
      begin
         mux = mux | (fu_result[i] & {$bits(wb_types_pkg::cdb_t){grant[i]}});
      end
   end

   assign cdb = mux;

   // some way is granted whenever any way requests.
   assign cdb_valid = |fu_valid;

endmodule

`default_nettype wire

// File: hw/core_cfg_pkg.sv
// Write-back path sizes
`default_nettype none

package core_cfg_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // datapath and bookkeeping widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // operands and results are plain integer words.
   localparam int data_w = 32;
   // destination tags name one of 32 architectural registers.
   localparam int tag_w = 5;
   // the reorder buffer holds eight operations in flight.
   localparam int rob_depth = 8;
   localparam int rob_id_w = 3;

   // two functional units share the common data bus.
   // way 0 wins the bus when both units request it.
   localparam int fu_ways = 2;
   localparam int fu_alu = 0;
   localparam int fu_mul = 1;

   // one shift-add step per result bit.
   localparam int mul_steps = 32;

endpackage

`default_nettype wire

// File: hw/mul_unit.sv
// Iterative shift-add multiplier
`default_nettype none

module mul_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  dispatch,
   input  wb_types_pkg::fu_op_t  fu_op,
   output logic                  busy,
   output logic                  fu_valid,
   input  logic                  fu_ready,
   output wb_types_pkg::cdb_t    fu_result
);

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_done
   } mul_state_e;

   mul_state_e                              state;
   logic                                    take;
   logic [$clog2(core_cfg_pkg::mul_steps+1)-1:0] step_cnt;
   logic [core_cfg_pkg::data_w-1:0]         mcand;
   logic [core_cfg_pkg::data_w-1:0]         mplier;
   logic [core_cfg_pkg::data_w-1:0]         acc;
   logic [core_cfg_pkg::tag_w-1:0]          tag_q;
   logic [core_cfg_pkg::rob_id_w-1:0]       id_q;

   assign take = dispatch && (fu_op.iss.op == wb_types_pkg::op_mul);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // run steps once per cycle until the counter reaches mul_steps.
   // the extra cycle spent on that last check puts the result out
   // mul_steps + 1 cycles after the dispatch edge.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= st_idle;
         step_cnt <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (take)
               begin
                  state    <= st_run;
                  step_cnt <= '0;
               end
            end
            st_run:
            begin
               if (step_cnt == core_cfg_pkg::mul_steps)
                  state <= st_done;
               else
                  step_cnt <= step_cnt + 1'b1;
            end
            // a granted result may be followed at once by the next multiply.
            st_done:
            begin
               if (fu_ready && take)
               begin
                  state    <= st_run;
                  step_cnt <= '0;
               end
               else if (fu_ready)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // datapath
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // each step adds the shifted multiplicand when the low multiplier bit
   // is set; bits above data_w fall off, which truncates the product.
   always_ff @(posedge clk)
   begin
      if (take && (state != st_run))
      begin
         mcand  <= fu_op.iss.a;
         mplier <= fu_op.iss.b;
         acc    <= '0;
         tag_q  <= fu_op.iss.tag;
         id_q   <= fu_op.rob_id;
      end
      else if ((state == st_run) && (step_cnt != core_cfg_pkg::mul_steps))
      begin
         if (mplier[0])
            acc <= acc + mcand;
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign fu_valid         = (state == st_done);
   assign fu_result.data   = acc;
   assign fu_result.tag    = tag_q;
   assign fu_result.rob_id = id_q;

   // free again once a held result is being granted.
   assign busy = (state == st_run) || ((state == st_done) && !fu_ready);

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
// Reorder buffer
`default_nettype none

module reorder_buffer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  issue_valid,
   input  wb_types_pkg::issue_t  issue,
   output logic                  issue_ready,
   input  logic                  alu_busy,
   input  logic                  mul_busy,
   output logic                  dispatch,
   output wb_types_pkg::fu_op_t  fu_op,
   input  logic                  cdb_valid,
   input  wb_types_pkg::cdb_t    cdb,
   output logic                  retire_valid,
   output wb_types_pkg::retire_t retire,
   input  logic                  retire_ready
);

   logic [core_cfg_pkg::rob_id_w-1:0] head;
   logic [core_cfg_pkg::rob_id_w-1:0] tail;
   logic [core_cfg_pkg::rob_id_w:0]   count;
   logic                              started;
   logic                              target_busy;
   logic                              accept;
   logic                              retire_fire;

   // per-slot state; only the complete bits are control.
   logic [core_cfg_pkg::rob_depth-1:0] cpl;
   logic [core_cfg_pkg::tag_w-1:0]     tag_mem  [core_cfg_pkg::rob_depth];
   logic [core_cfg_pkg::data_w-1:0]    data_mem [core_cfg_pkg::rob_depth];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // issue and steering
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // an issue is held off while the unit it would go to still holds a
   // result, or while every slot is taken.
   assign target_busy = (issue.op == wb_types_pkg::op_mul) ? mul_busy : alu_busy;

   assign issue_ready = started &&
                        (count != core_cfg_pkg::rob_depth) &&
                        !target_busy;

   assign accept = issue_valid && issue_ready;

   // both units see the operation; each picks out its own opcodes.
   assign dispatch     = accept;
   assign fu_op.iss    = issue;
   assign fu_op.rob_id = tail;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // retire
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // a free slot never has its complete bit set, so the head bit alone
   // tells whether the oldest operation is done.
   assign retire_valid = cpl[head];
   assign retire.data  = data_mem[head];
   assign retire.tag   = tag_mem[head];
   assign retire_fire  = retire_valid && retire_ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pointers and complete bits
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // the depth is a power of two, so the pointers wrap by overflow.
   // allocation, bus write and retire always touch different slots.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head    <= '0;
         tail    <= '0;
         count   <= '0;
         cpl     <= '0;
         started <= 1'b0;
      end
      else
      begin
         started <= 1'b1;
         if (accept)
         begin
            tail      <= tail + 1'b1;
            cpl[tail] <= 1'b0;
         end
         if (cdb_valid)
            cpl[cdb.rob_id] <= 1'b1;
         if (retire_fire)
         begin
            head      <= head + 1'b1;
            cpl[head] <= 1'b0;
         end
         case ({accept, retire_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // result payload lands in the slot the bus names.
   always_ff @(posedge clk)
   begin
      if (cdb_valid)
      begin
         data_mem[cdb.rob_id] <= cdb.data;
         tag_mem[cdb.rob_id]  <= cdb.tag;
      end
   end

endmodule

`default_nettype wire

// File: hw/wb_path_top.sv
// Write-back path top level
`default_nettype none

module wb_path_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  issue_valid,
   input  wb_types_pkg::issue_t  issue,
   output logic                  issue_ready,
   output logic                  retire_valid,
   output wb_types_pkg::retire_t retire,
   input  logic                  retire_ready
);

   logic                                           dispatch;
   wb_types_pkg::fu_op_t                           fu_op;
   logic                                           alu_busy;
   logic                                           mul_busy;
   logic [core_cfg_pkg::fu_ways-1:0]               fu_valid;
   logic [core_cfg_pkg::fu_ways-1:0]               fu_ready;
   wb_types_pkg::cdb_t [core_cfg_pkg::fu_ways-1:0] fu_result;
   logic                                           cdb_valid;
   wb_types_pkg::cdb_t                             cdb;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reorder buffer and functional units
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   reorder_buffer u_rob (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid),
      .issue        (issue),
      .issue_ready  (issue_ready),
      .alu_busy     (alu_busy),
      .mul_busy     (mul_busy),
      .dispatch     (dispatch),
      .fu_op        (fu_op),
      .cdb_valid    (cdb_valid),
      .cdb          (cdb),
      .retire_valid (retire_valid),
      .retire       (retire),
      .retire_ready (retire_ready)
   );

   // the ALU sits on way 0 and so wins the bus over the multiplier.
   alu_unit u_alu (
      .clk       (clk),
      .rst_n     (rst_n),
      .dispatch  (dispatch),
      .fu_op     (fu_op),
      .busy      (alu_busy),
      .fu_valid  (fu_valid[core_cfg_pkg::fu_alu]),
      .fu_ready  (fu_ready[core_cfg_pkg::fu_alu]),
      .fu_result (fu_result[core_cfg_pkg::fu_alu])
   );

   mul_unit u_mul (
      .clk       (clk),
      .rst_n     (rst_n),
      .dispatch  (dispatch),
      .fu_op     (fu_op),
      .busy      (mul_busy),
      .fu_valid  (fu_valid[core_cfg_pkg::fu_mul]),
      .fu_ready  (fu_ready[core_cfg_pkg::fu_mul]),
      .fu_result (fu_result[core_cfg_pkg::fu_mul])
   );

   cdb_arbiter u_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .fu_valid  (fu_valid),
      .fu_result (fu_result),
      .fu_ready  (fu_ready),
      .cdb_valid (cdb_valid),
      .cdb       (cdb)
   );

endmodule

`default_nettype wire

// File: hw/wb_types_pkg.sv
// Write-back record types
`default_nettype none

package wb_types_pkg;

   // opcodes; op_mul goes to the multiplier and the rest to the ALU.
   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_and,
      op_xor,
      op_mul
   } op_e;

   // one operation as it arrives on the issue port.
   typedef struct packed {
      op_e                              op;
      logic [core_cfg_pkg::data_w-1:0]  a;
      logic [core_cfg_pkg::data_w-1:0]  b;
      logic [core_cfg_pkg::tag_w-1:0]   tag;
   } issue_t;

   // the issued operation together with its reorder slot.
   typedef struct packed {
      issue_t                           iss;
      logic [core_cfg_pkg::rob_id_w-1:0] rob_id;
   } fu_op_t;

   // a finished result on the common data bus.
   typedef struct packed {
      logic [core_cfg_pkg::data_w-1:0]   data;
      logic [core_cfg_pkg::tag_w-1:0]    tag;
      logic [core_cfg_pkg::rob_id_w-1:0] rob_id;
   } cdb_t;

   // one in-order retirement.
   typedef struct packed {
      logic [core_cfg_pkg::data_w-1:0] data;
      logic [core_cfg_pkg::tag_w-1:0]  tag;
   } retire_t;

endpackage

`default_nettype wire

// File: project.f
hw/core_cfg_pkg.sv
hw/wb_types_pkg.sv
hw/cdb_arbiter.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reorder_buffer.sv
hw/wb_path_top.sv
dv/wb_path_chk.sv
dv/wb_path_tb.sv
